/* Makefile */
# verilator build and run of tb_io_soc

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_io_soc -o Vtb_io_soc

run: build
	./obj_dir/Vtb_io_soc > sim.log 2>&1 || echo "simulation exited with an error" >> sim.log
	cat sim.log
	@if grep -q "FAIL: see errors above" sim.log; then exit 1; fi
	@grep -q "PASS: all tests" sim.log

lint:
	verilator --lint-only -Wall --timing -f list.f --top-module tb_io_soc

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

/* bus_response.sv */
`default_nettype none
`timescale 1ns/1ps
`include "io_cfg.svh"

module bus_response (
	input wire clk100,
	input wire rst,
	input wire io_map_pkg::io_sel_t sel_i,
	input wire start_i,
	input wire io_map_pkg::io_rdata_t rdata_i,
	output io_bus_pkg::io_resp_t resp_o
);

	localparam int tw = $clog2(`IO_BUS_TIMEOUT + 1);
	localparam logic [tw-1:0] tmo_last = tw'(`IO_BUS_TIMEOUT - 1); // err registered next edge

	logic any_sel;
	logic ack_q;
	logic rd_q; // ack of a read
	logic err_q;
	logic tmo_act; // timeout armed
	logic [tw-1:0] tmo_cnt; // cycles since the access started

	assign any_sel = sel_i.leds | sel_i.rst | sel_i.rnd;

	// ------------------------------
	// ack and bus error timeout
	// ------------------------------
	always_ff @(posedge clk100) begin
		if (rst) begin
			ack_q <= 1'b0;
			rd_q <= 1'b0;
			err_q <= 1'b0;
			tmo_act <= 1'b0;
			tmo_cnt <= '0;
		end
		else begin
			ack_q <= any_sel;
			rd_q <= any_sel & ~sel_i.we;
			err_q <= 1'b0; // single cycle pulse
			if (tmo_act) begin
				tmo_cnt <= tmo_cnt + 1'b1;
				if (tmo_cnt == tmo_last) begin
					err_q <= 1'b1;
					tmo_act <= 1'b0;
				end
			end
			if (ack_q)
				tmo_act <= 1'b0; // device answered
			if (start_i) begin
				tmo_act <= 1'b1; // every access restarts the count
				tmo_cnt <= tw'(1);
			end
		end
	end

	// read words are zero unless their device was read
	always_comb begin
		resp_o.ack = ack_q;
		resp_o.err = err_q;
		resp_o.dat = rd_q ? (rdata_i.ctrl_dat | rdata_i.rand_dat) : 32'd0;
	end

endmodule

`default_nettype wire

/* io_addr_decode.sv */
`default_nettype none
`timescale 1ns/1ps
`include "io_cfg.svh"

module io_addr_decode (
	input wire clk100,
	input wire rst,
	input wire io_bus_pkg::io_req_t req_i,
	output io_map_pkg::io_sel_t sel_o,
	output logic start_o
);
	import io_bus_pkg::*;

	localparam logic [23:0] blk_leds = `IO_BLK_LEDS;
	localparam logic [23:0] blk_rst = `IO_BLK_RST;
	localparam logic [23:0] blk_rand = `IO_BLK_RAND;
	localparam logic [15:0] io_page = blk_leds[23:8]; // all three blocks sit in one page

	io_adr_u adr;
	logic pending; // access seen, waiting for stb to drop
	logic new_acc;
	logic page_hit;

	assign adr = req_i.adr;
	assign new_acc = req_i.cyc & req_i.stb & ~pending; // first cycle only
	assign page_hit = adr.pg.page == io_page; // coarse window first

	always_ff @(posedge clk100) begin
		if (rst)
			pending <= 1'b0;
		else if (new_acc)
			pending <= 1'b1;
		else if (!req_i.stb)
			pending <= 1'b0; // master finished, rearm
	end

	// ------------------------------
	// block decode, valid one cycle
	// ------------------------------
	always_comb begin
		sel_o.leds = new_acc & page_hit & (adr.blk.block == blk_leds);
		sel_o.rst = new_acc & page_hit & (adr.blk.block == blk_rst);
		sel_o.rnd = new_acc & page_hit & (adr.blk.block == blk_rand);
		sel_o.we = req_i.we; // payload passes as is
		sel_o.sel = req_i.sel;
		sel_o.wdat = req_i.dat;
	end

	assign start_o = new_acc; // mapped or not, starts the timeout

endmodule

`default_nettype wire

/* io_bus_pkg.sv */
`default_nettype none

package io_bus_pkg;

	// ------------------------------
	// master side request
	// ------------------------------
	typedef struct packed {
		logic cyc; // bus cycle in progress
		logic stb; // strobe, held until ack or err
		logic we; // 1 = write
		logic [3:0] sel; // byte lanes
		logic [31:0] adr;
		logic [31:0] dat; // write data
	} io_req_t;

	// slave side response
	typedef struct packed {
		logic ack; // one cycle
		logic err; // bus error from the timeout
		logic [31:0] dat; // read data, zero outside the ack cycle
	} io_resp_t;

	// ------------------------------
	// address, two decode views
	// ------------------------------
	typedef union packed {
		struct packed {
			logic [15:0] page; // 64k page, i/o window
			logic [15:0] offset;
		} pg;
		struct packed {
			logic [23:0] block; // 256 byte device block
			logic [7:0] regno; // register within the block
		} blk;
	} io_adr_u;

endpackage

`default_nettype wire

/* io_cfg.svh */
`ifndef IO_CFG_SVH
`define IO_CFG_SVH

// ------------------------------
// i/o map, block codes (adr[31:8])
// ------------------------------
`define IO_BLK_LEDS 24'hFD0FFF // led register
`define IO_BLK_RST 24'hFD0FFC // node reset / clock enable
`define IO_BLK_RAND 24'hFD0FFD // random number source

// ------------------------------
// reset register fields
// ------------------------------
`define IO_RST_HOLD 64 // cycles a node reset stays asserted
`define IO_CLKEN_INIT 3'b110 // node 1 and 2 clocks on at power up
`define IO_CLKEN_LO 16 // clken field in data bits 18:16
`define IO_CLKEN_HI 18

// ------------------------------
// tick interrupt, in clk100 cycles
// ------------------------------
`define IO_TICK_PERIOD 1000000 // 100 Hz at 100 MHz
`define IO_TICK_ON 150
`define IO_TICK_OFF 200

// bus error after this many cycles with no ack
`define IO_BUS_TIMEOUT 16

// ------------------------------
// random source
// ------------------------------
`define IO_LFSR_TAPS 32'h80200003 // galois feedback mask
`define IO_LFSR_SEED 32'h00000001 // also used for a zero seed write

`endif

/* io_map_pkg.sv */
`default_nettype none

package io_map_pkg;

	// one-cycle device selects plus the write payload
	typedef struct packed {
		logic leds; // led register
		logic rst; // node reset register
		logic rnd; // random source
		logic we;
		logic [3:0] sel; // byte lanes from the request
		logic [31:0] wdat;
	} io_sel_t;

	// ------------------------------
	// read return, one word per device group
	// ------------------------------
	typedef struct packed {
		logic [31:0] ctrl_dat; // leds / reset register
		logic [31:0] rand_dat; // lfsr state
	} io_rdata_t;

endpackage

`default_nettype wire

/* io_soc_assert.sv */
`default_nettype none
`timescale 1ns/1ps

module io_soc_assert (
	input wire clk100,
	input wire rst,
	input wire io_map_pkg::io_sel_t sel_i,
	input wire io_bus_pkg::io_resp_t resp_o
);

	logic any_sel; // one device selected this cycle

	assign any_sel = sel_i.leds | sel_i.rst | sel_i.rnd;

	// ------------------------------
	// response timing
	// ------------------------------
	ack_err_excl: assert property (@(posedge clk100) disable iff (rst)
		!(resp_o.ack && resp_o.err))
		else $error("ack and err high in the same cycle");

	ack_one_cycle: assert property (@(posedge clk100) disable iff (rst)
		resp_o.ack |=> !resp_o.ack)
		else $error("ack wider than one cycle");

	// select then ack, no gap
	ack_after_sel: assert property (@(posedge clk100) disable iff (rst)
		any_sel |=> resp_o.ack)
		else $error("select not followed by ack");

endmodule

bind bus_response io_soc_assert uassert1 (
	.clk100(clk100),
	.rst(rst),
	.sel_i(sel_i),
	.resp_o(resp_o)
);

`default_nettype wire

/* io_soc_top.sv */
`default_nettype none
`timescale 1ns/1ps
`include "io_cfg.svh"

module io_soc_top #(
	parameter int tick_period = `IO_TICK_PERIOD
) (
	input wire clk100,
	input wire rst,
	input wire io_bus_pkg::io_req_t req_i,
	output io_bus_pkg::io_resp_t resp_o,
	output logic [7:0] led_o,
	output logic [15:0] node_rst_o,
	output logic [2:0] clken_o,
	output logic tick_irq_o
);
	import io_map_pkg::*;

	io_sel_t sel; // one-cycle device selects
	io_rdata_t rdata; // read words back to the response side
	logic start; // any new access

	// ------------------------------
	// request side
	// ------------------------------
	io_addr_decode udec1 (
		.clk100(clk100),
		.rst(rst),
		.req_i(req_i),
		.sel_o(sel),
		.start_o(start)
	);

	// ------------------------------
	// devices
	// ------------------------------
	sys_ctrl_regs uregs1 (
		.clk100(clk100),
		.rst(rst),
		.sel_i(sel),
		.rdat_o(rdata.ctrl_dat),
		.led_o(led_o),
		.node_rst_o(node_rst_o),
		.clken_o(clken_o)
	);

	lfsr_random urand1 (
		.clk100(clk100),
		.rst(rst),
		.sel_i(sel),
		.rdat_o(rdata.rand_dat)
	);

	tick_timer #(.tick_period(tick_period)) utick1 (
		.clk100(clk100),
		.rst(rst),
		.tick_irq_o(tick_irq_o)
	);

	// ack, read data, bus error
	bus_response uresp1 (
		.clk100(clk100),
		.rst(rst),
		.sel_i(sel),
		.start_i(start),
		.rdata_i(rdata),
		.resp_o(resp_o)
	);

endmodule

`default_nettype wire

/* lfsr_random.sv */
`default_nettype none
`timescale 1ns/1ps
`include "io_cfg.svh"

module lfsr_random (
	input wire clk100,
	input wire rst,
	input wire io_map_pkg::io_sel_t sel_i,
	output logic [31:0] rdat_o
);

	localparam logic [31:0] taps = `IO_LFSR_TAPS;
	localparam logic [31:0] seed = `IO_LFSR_SEED;

	logic [31:0] state;
	logic [31:0] step_val; // state after one galois step
	logic rd;
	logic wr;

	assign rd = sel_i.rnd & ~sel_i.we;
	assign wr = sel_i.rnd & sel_i.we;

	// shift right, fold taps in when a one drops out
	assign step_val = {1'b0, state[31:1]} ^ (state[0] ? taps : 32'd0);

	// ------------------------------
	// state, seed on write, step on read
	// ------------------------------
	always_ff @(posedge clk100) begin
		if (rst)
			state <= seed;
		else if (wr)
			state <= (sel_i.wdat == 32'd0) ? seed : sel_i.wdat; // all zero would lock up
		else if (rd)
			state <= step_val;
	end

	// value before the step, seen in the ack cycle
	always_ff @(posedge clk100) begin
		if (rd)
			rdat_o <= state;
		else
			rdat_o <= 32'd0;
	end

endmodule

`default_nettype wire

/* list.f */
+incdir+.
io_bus_pkg.sv
io_map_pkg.sv
io_addr_decode.sv
sys_ctrl_regs.sv
tick_timer.sv
lfsr_random.sv
bus_response.sv
io_soc_top.sv
io_soc_assert.sv
tb_io_soc.sv

/* sys_ctrl_regs.sv */
`default_nettype none
`timescale 1ns/1ps
`include "io_cfg.svh"

module sys_ctrl_regs (
	input wire clk100,
	input wire rst,
	input wire io_map_pkg::io_sel_t sel_i,
	output logic [31:0] rdat_o,
	output logic [7:0] led_o,
	output logic [15:0] node_rst_o,
	output logic [2:0] clken_o
);

	localparam logic [6:0] hold = 7'(`IO_RST_HOLD);

	logic [7:0] led_q;
	logic [15:0] rst_bits; // per node reset requests
	logic [6:0] rst_cnt; // release counter
	logic [2:0] clken_q;
	logic wr_led;
	logic wr_rst_lo; // bytes 1:0, reset bits
	logic wr_rst_hi; // bytes 3:2, clock enables
	logic held;

	assign wr_led = sel_i.leds & sel_i.we & sel_i.sel[0];
	assign wr_rst_lo = sel_i.rst & sel_i.we & (|sel_i.sel[1:0]);
	assign wr_rst_hi = sel_i.rst & sel_i.we & (|sel_i.sel[3:2]);
	assign held = rst_cnt < hold;

	// ------------------------------
	// led register
	// ------------------------------
	always_ff @(posedge clk100) begin
		if (rst)
			led_q <= 8'd0;
		else if (wr_led)
			led_q <= sel_i.wdat[7:0];
	end

	// ------------------------------
	// node reset and clock enable
	// ------------------------------
	always_ff @(posedge clk100) begin
		if (rst) begin
			rst_bits <= 16'd0;
			rst_cnt <= hold; // idle, nothing to release
			clken_q <= `IO_CLKEN_INIT;
		end
		else begin
			if (held)
				rst_cnt <= rst_cnt + 7'd1;
			else
				rst_bits <= 16'd0; // hold time over, release
			if (wr_rst_lo) begin
				rst_bits <= sel_i.wdat[15:0];
				rst_cnt <= 7'd0; // restart the hold
				// resetting node 2 also turns its clock on
				clken_q[2] <= clken_q[2] | (|sel_i.wdat[5:4]);
			end
			if (wr_rst_hi)
				clken_q <= sel_i.wdat[`IO_CLKEN_HI:`IO_CLKEN_LO]; // wins over the or above
		end
	end

	assign led_o = led_q;
	assign node_rst_o = held ? rst_bits : 16'd0;
	assign clken_o = clken_q;

	// readback, zero unless read in the cycle before
	always_ff @(posedge clk100) begin
		if (sel_i.leds & ~sel_i.we)
			rdat_o <= {24'd0, led_q};
		else if (sel_i.rst & ~sel_i.we)
			rdat_o <= {13'd0, clken_q, rst_bits};
		else
			rdat_o <= 32'd0;
	end

endmodule

`default_nettype wire

/* tb_io_soc.sv */
`default_nettype none
`timescale 1ns/1ps
`include "io_cfg.svh"

module tb_io_soc;
	import io_bus_pkg::*;

	localparam logic [31:0] adr_leds = {`IO_BLK_LEDS, 8'h00};
	localparam logic [31:0] adr_rst = {`IO_BLK_RST, 8'h00};
	localparam logic [31:0] adr_rand = {`IO_BLK_RAND, 8'h00};
	localparam logic [31:0] adr_none = 32'hFD0FF000; // i/o page, but no block
	localparam int max_wait = 100; // bus wait guard, cycles

	logic clk100 = 1'b0;
	logic rst;
	io_req_t req;
	io_resp_t resp;
	logic [7:0] led;
	logic [15:0] node_rst;
	logic [2:0] clken;
	logic tick_irq;
	int unsigned cycle = 0; // rising edges so far
	int unsigned ack_cycle; // edge count at the last ack or err
	int errors = 0;
	int tests_ok = 0;
	int tests_bad = 0;

	always #5 clk100 = ~clk100; // 100 MHz
	always @(posedge clk100) cycle <= cycle + 1;

	io_soc_top #(.tick_period(400)) uut (
		.clk100(clk100),
		.rst(rst),
		.req_i(req),
		.resp_o(resp),
		.led_o(led),
		.node_rst_o(node_rst),
		.clken_o(clken),
		.tick_irq_o(tick_irq)
	);

	// ------------------------------
	// helpers
	// ------------------------------
	task automatic next_edge();
		@(posedge clk100);
		#1; // drive and sample just past the edge
	endtask

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("mismatch %s: expected %h, actual %h", name, expected, actual);
			errors++;
		end
	endtask

	// reference galois step, taps 0x80200003
	function automatic logic [31:0] galois_step(input logic [31:0] s);
		return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
	endfunction

	task automatic report_test(input string name, input int err_before);
		if (errors == err_before) begin
			$display("test %s finished, no errors", name);
			tests_ok++;
		end
		else begin
			$display("test %s finished with %0d errors", name, errors - err_before);
			tests_bad++;
		end
	endtask

	// ------------------------------
	// bus master
	// ------------------------------
	task automatic bus_cycle(input logic we, input logic [31:0] adr, input logic [3:0] sel,
			input logic [31:0] wdat, output logic [31:0] rdat, output logic ack,
			output logic err);
		int n;
		req.cyc = 1'b1;
		req.stb = 1'b1;
		req.we = we;
		req.sel = sel;
		req.adr = adr;
		req.dat = wdat;
		ack = 1'b0;
		err = 1'b0;
		rdat = '0;
		n = 0;
		while (!ack && !err && n < max_wait) begin // hold stb until answered
			next_edge();
			n++;
			ack = resp.ack;
			err = resp.err;
			rdat = resp.dat;
		end
		if (!ack && !err) begin
			$display("no ack or err within %0d cycles for address %h", max_wait, adr);
			errors++;
		end
		ack_cycle = cycle;
		req = '0;
		next_edge(); // stb low at least one edge
	endtask

	task automatic bus_write(input string name, input logic [31:0] adr, input logic [3:0] sel,
			input logic [31:0] wdat);
		logic [31:0] d;
		logic a;
		logic x;
		bus_cycle(1'b1, adr, sel, wdat, d, a, x);
		check(name, 32'h1, 32'(a));
		check(name, 32'h0, d); // no read data on a write
	endtask

	task automatic bus_read(input logic [31:0] adr, input logic [3:0] sel,
			output logic [31:0] dat, output logic ack, output logic err);
		bus_cycle(1'b0, adr, sel, 32'h0, dat, ack, err);
	endtask

	// ------------------------------
	// directed tests
	// ------------------------------
	task automatic reset_and_leds();
		int e0;
		logic [7:0] b;
		logic [31:0] d;
		logic a;
		logic x;
		e0 = errors;
		check("reset led", 32'h0, 32'(led));
		check("reset clken", 32'h6, 32'(clken));
		check("reset node_rst", 32'h0, 32'(node_rst));
		check("reset tick", 32'h0, 32'(tick_irq));
		check("reset ack", 32'h0, 32'(resp.ack));
		check("reset err", 32'h0, 32'(resp.err));
		repeat (4) begin
			b = 8'($urandom);
			bus_write("led write ack", adr_leds, 4'h1, {24'($urandom), b}); // upper bytes ignored
			check("led output", 32'(b), 32'(led));
			bus_read(adr_leds, 4'hF, d, a, x);
			check("led read ack", 32'h1, 32'(a));
			check("led readback", 32'(b), d);
		end
		report_test("reset_and_leds", e0);
	endtask

	task automatic reset_release();
		int e0;
		int n;
		int unsigned c0;
		logic [31:0] d;
		logic a;
		logic x;
		e0 = errors;
		bus_write("clken clear ack", adr_rst, 4'hC, 32'h0); // so bit 2 has to come back
		bus_write("reset write ack", adr_rst, 4'h3, 32'h0000_0034);
		c0 = ack_cycle; // write edge
		check("node_rst held", 32'h34, 32'(node_rst));
		check("clken bit 2 from reset", 32'h4, 32'(clken));
		bus_read(adr_rst, 4'hF, d, a, x);
		check("reset read ack", 32'h1, 32'(a));
		check("reset readback", 32'h0004_0034, d);
		n = 0;
		while (node_rst == 16'h0034 && n < 200) begin
			next_edge();
			n++;
		end
		check("node_rst after release", 32'h0, 32'(node_rst));
		check("node_rst hold cycles", 32'd64, cycle - c0);
		report_test("reset_release", e0);
	endtask

	task automatic clock_enable();
		int e0;
		logic [31:0] w;
		logic [31:0] d;
		logic a;
		logic x;
		e0 = errors;
		w = ($urandom & 32'hFFF8_FFFF) | 32'h0001_0000; // clken field 001
		bus_write("clken write ack", adr_rst, 4'hC, w);
		check("clken output", 32'h1, 32'(clken));
		check("node_rst untouched", 32'h0, 32'(node_rst)); // low half not selected
		bus_read(adr_rst, 4'hF, d, a, x);
		check("clken read ack", 32'h1, 32'(a));
		check("clken readback", 32'h0001_0000, d);
		report_test("clock_enable", e0);
	endtask

	task automatic random_source();
		int e0;
		logic [31:0] s;
		logic [31:0] d;
		logic a;
		logic x;
		e0 = errors;
		s = $urandom;
		if (s == 32'h0)
			s = 32'h1; // nonzero seed only
		bus_write("seed write ack", adr_rand, 4'hF, s);
		repeat (5) begin
			bus_read(adr_rand, 4'hF, d, a, x);
			check("random read ack", 32'h1, 32'(a));
			check("random value", s, d);
			s = galois_step(s); // next expected state
		end
		report_test("random_source", e0);
	endtask

	task automatic bus_error();
		int e0;
		logic [31:0] d;
		logic a;
		logic x;
		e0 = errors;
		bus_read(adr_none, 4'hF, d, a, x);
		check("unmapped err", 32'h1, 32'(x));
		check("unmapped ack", 32'h0, 32'(a));
		check("unmapped data", 32'h0, d);
		report_test("bus_error", e0);
	endtask

	task automatic wait_tick_rise(output int unsigned at);
		int n;
		logic prev;
		n = 0;
		prev = tick_irq;
		next_edge();
		while (!(tick_irq && !prev) && n < 1000) begin
			prev = tick_irq;
			next_edge();
			n++;
		end
		if (n >= 1000) begin
			$display("tick interrupt did not rise within 1000 cycles");
			errors++;
		end
		at = cycle;
	endtask

	task automatic tick_irq_timing();
		int e0;
		int n;
		int high;
		int unsigned r1;
		int unsigned r2;
		e0 = errors;
		wait_tick_rise(r1);
		high = 0;
		n = 0;
		while (tick_irq && n < 1000) begin // width of the pulse
			high++;
			next_edge();
			n++;
		end
		wait_tick_rise(r2);
		check("tick high cycles", 32'd50, 32'(high));
		check("tick period", 32'd400, r2 - r1);
		report_test("tick_irq_timing", e0);
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------
	initial begin
		void'($urandom(90)); // fixed seed, data patterns only
		rst = 1'b1;
		req = '0;
		repeat (10) next_edge();
		rst = 1'b0;
		reset_and_leds();
		reset_release();
		clock_enable();
		random_source();
		bus_error();
		tick_irq_timing();
		$display("tests passed %0d, failed %0d, errors %0d", tests_ok, tests_bad, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end
		else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tick_timer.sv */
`default_nettype none
`timescale 1ns/1ps
`include "io_cfg.svh"

module tick_timer #(
	parameter int tick_period = `IO_TICK_PERIOD,
	parameter int tick_on = `IO_TICK_ON, // count where irq rises
	parameter int tick_off = `IO_TICK_OFF // count where irq falls
) (
	input wire clk100,
	input wire rst,
	output logic tick_irq_o
);

	localparam int cw = $clog2(tick_period + 1);

	logic [cw-1:0] cnt; // runs 1 .. tick_period

	// ------------------------------
	// free running, no bus access
	// ------------------------------
	always_ff @(posedge clk100) begin
		if (rst) begin
			cnt <= cw'(1);
			tick_irq_o <= 1'b0;
		end
		else begin
			if (cnt == cw'(tick_period))
				cnt <= cw'(1); // wrap
			else
				cnt <= cnt + 1'b1;
			if (cnt == cw'(tick_on))
				tick_irq_o <= 1'b1;
			else if (cnt == cw'(tick_off))
				tick_irq_o <= 1'b0; // high for tick_off - tick_on cycles
		end
	end

endmodule

`default_nettype wire
